// ==== Bender.yml ====
package:
  name: des_core

sources:
  - logic/des_pkg.sv
  - logic/des_ctrl.sv
  - logic/des_key_schedule.sv
  - logic/des_block_state.sv
  - logic/des_round_f.sv
  - logic/des_core.sv
  - target: test
    files:
      - verif/des_tb.sv

// ==== list.f ====
logic/des_pkg.sv
logic/des_ctrl.sv
logic/des_key_schedule.sv
logic/des_block_state.sv
logic/des_round_f.sv
logic/des_core.sv
verif/des_tb.sv

// ==== logic/des_block_state.sv ====
`timescale 1ns/1ps

module des_block_state (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load,
    input  logic                step,
    input  des_pkg::des_block_t block,
    input  des_pkg::des_half_t  f_out,
    output des_pkg::des_half_t  r_half,
    output des_pkg::des_block_t dout
);

    des_pkg::des_halves_t lr_q;
    des_pkg::des_halves_t lr_ip;
    des_pkg::des_halves_t lr_swap;

    assign lr_ip = des_pkg::des_halves_t'(des_pkg::des_ip(block));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lr_q <= '0;
        end else if (load) begin
            lr_q <= lr_ip;
        end else if (step) begin
            // one feistel round
            lr_q.l <= lr_q.r;
            lr_q.r <= lr_q.l ^ f_out;
        end
    end

    assign r_half = lr_q.r;

    // halves swapped once more before FP
    always_comb begin
        lr_swap.l = lr_q.r;
        lr_swap.r = lr_q.l;
    end

    assign dout = des_pkg::des_fp(des_pkg::des_block_t'(lr_swap));

endmodule

// ==== logic/des_core.sv ====
`timescale 1ns/1ps

module des_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  des_pkg::des_req_t   req,
    output logic                busy,
    output logic                done,
    output des_pkg::des_block_t dout
);

    logic                 load;
    logic                 step;
    des_pkg::des_round_t  round;
    des_pkg::des_subkey_t subkey;
    des_pkg::des_half_t   r_half;
    des_pkg::des_half_t   f_out;

    des_ctrl u_ctrl (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .load  (load),
        .step  (step),
        .busy  (busy),
        .done  (done),
        .round (round)
    );

    des_key_schedule u_key_schedule (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .step    (step),
        .round   (round),
        .key     (req.key),
        .decrypt (req.decrypt),
        .subkey  (subkey)
    );

    des_block_state u_block_state (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (load),
        .step   (step),
        .block  (req.block),
        .f_out  (f_out),
        .r_half (r_half),
        .dout   (dout)
    );

    des_round_f u_round_f (
        .r_half (r_half),
        .subkey (subkey),
        .f_out  (f_out)
    );

endmodule

// ==== logic/des_ctrl.sv ====
`timescale 1ns/1ps

module des_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    output logic                load,
    output logic                step,
    output logic                busy,
    output logic                done,
    output des_pkg::des_round_t round
);

    typedef enum logic {
        IDLE,
        RUN
    } state_t;

    state_t              state_q;
    des_pkg::des_round_t round_q;
    logic                last_step;

    // start is ignored outside idle
    assign load      = (state_q == IDLE) && start;
    assign step      = (state_q == RUN);
    assign busy      = (state_q == RUN);
    assign round     = round_q;
    assign last_step = step && (round_q == des_pkg::des_round_t'(des_pkg::NUM_ROUNDS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            round_q <= '0;
            done    <= 1'b0;
        end else begin
            done <= last_step;
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q <= RUN;
                        round_q <= '0;
                    end
                end
                RUN: begin
                    round_q <= round_q + 4'd1;
                    if (last_step) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// ==== logic/des_key_schedule.sv ====
`timescale 1ns/1ps

module des_key_schedule (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  logic                 step,
    input  des_pkg::des_round_t  round,
    input  des_pkg::des_key_t    key,
    input  logic                 decrypt,
    output des_pkg::des_subkey_t subkey
);

    des_pkg::des_cd_t    cd_q;
    des_pkg::des_cd_t    cd_pc1;
    logic                decrypt_q;
    des_pkg::des_round_t shift_idx;
    logic [1:0]          shift_amt;

    function automatic des_pkg::des_cd_half_t rotl(input des_pkg::des_cd_half_t x,
                                                   input logic [1:0] n);
        return (x << n) | (x >> (des_pkg::CD_W - n));
    endfunction

    function automatic des_pkg::des_cd_half_t rotr(input des_pkg::des_cd_half_t x,
                                                   input logic [1:0] n);
        return (x >> n) | (x << (des_pkg::CD_W - n));
    endfunction

    // decrypt walks the schedule backwards from round 16, whose C/D equals PC-1 itself
    always_comb begin
        cd_pc1 = des_pkg::des_pc1(key);
        if (decrypt_q) begin
            shift_idx = des_pkg::des_round_t'(des_pkg::NUM_ROUNDS - 1) - round;
        end else begin
            shift_idx = round + 4'd1;
        end
        shift_amt = 2'(des_pkg::SHIFT_TABLE[shift_idx]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cd_q      <= '0;
            decrypt_q <= 1'b0;
        end else if (load) begin
            decrypt_q <= decrypt;
            if (decrypt) begin
                cd_q <= cd_pc1;
            end else begin
                cd_q.c <= rotl(cd_pc1.c, 2'(des_pkg::SHIFT_TABLE[0]));
                cd_q.d <= rotl(cd_pc1.d, 2'(des_pkg::SHIFT_TABLE[0]));
            end
        end else if (step) begin
            if (decrypt_q) begin
                cd_q.c <= rotr(cd_q.c, shift_amt);
                cd_q.d <= rotr(cd_q.d, shift_amt);
            end else begin
                cd_q.c <= rotl(cd_q.c, shift_amt);
                cd_q.d <= rotl(cd_q.d, shift_amt);
            end
        end
    end

    assign subkey = des_pkg::des_pc2(cd_q);

endmodule

// ==== logic/des_pkg.sv ====
package des_pkg;

    localparam int BLOCK_W    = 64;
    localparam int HALF_W     = 32;
    localparam int KEY_W      = 64;
    localparam int SUBKEY_W   = 48;
    localparam int CD_W       = 28;
    localparam int NUM_ROUNDS = 16;

    typedef logic [BLOCK_W-1:0]  des_block_t;
    typedef logic [HALF_W-1:0]   des_half_t;
    typedef logic [KEY_W-1:0]    des_key_t;
    typedef logic [SUBKEY_W-1:0] des_subkey_t;
    typedef logic [CD_W-1:0]     des_cd_half_t;
    typedef logic [3:0]          des_round_t;

    typedef struct packed {
        des_half_t l;
        des_half_t r;
    } des_halves_t;

    typedef struct packed {
        des_cd_half_t c;
        des_cd_half_t d;
    } des_cd_t;

    typedef struct packed {
        logic       decrypt;
        des_key_t   key;
        des_block_t block;
    } des_req_t;

    // bit 1 is the msb in all tables
    localparam int unsigned IP_TABLE [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam int unsigned FP_TABLE [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41,  9, 49, 17, 57, 25
    };

    localparam int unsigned E_TABLE [48] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,  8,  9, 10, 11,
        12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
        22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
    };

    localparam int unsigned P_TABLE [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    localparam int unsigned PC1_TABLE [56] = '{
        57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
    };

    localparam int unsigned PC2_TABLE [48] = '{
        14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10, 23, 19, 12,  4,
        26,  8, 16,  7, 27, 20, 13,  2, 41, 52, 31, 37, 47, 55, 30, 40,
        51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    // entry index is row * 16 + column
    localparam logic [3:0] SBOX_TABLE [8][64] = '{
        '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
           0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
           4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
          15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
        '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
           3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
           0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
          13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
        '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
          13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
          13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
           1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
        '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
          13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
          10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
           3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
        '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
          14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
           4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
          11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
        '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
          10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
           9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
           4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
        '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
          13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
           1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
           6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
        '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
           1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
           7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
           2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
    };

    localparam int unsigned SHIFT_TABLE [16] = '{
        1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
    };

    function automatic des_block_t des_ip(input des_block_t b);
        des_block_t o;
        for (int i = 0; i < BLOCK_W; i++) o[BLOCK_W-1-i] = b[BLOCK_W - IP_TABLE[i]];
        return o;
    endfunction

    function automatic des_block_t des_fp(input des_block_t b);
        des_block_t o;
        for (int i = 0; i < BLOCK_W; i++) o[BLOCK_W-1-i] = b[BLOCK_W - FP_TABLE[i]];
        return o;
    endfunction

    // 32 -> 48 bit expansion
    function automatic des_subkey_t des_expand(input des_half_t h);
        des_subkey_t o;
        for (int i = 0; i < SUBKEY_W; i++) o[SUBKEY_W-1-i] = h[HALF_W - E_TABLE[i]];
        return o;
    endfunction

    function automatic des_half_t des_perm_p(input des_half_t h);
        des_half_t o;
        for (int i = 0; i < HALF_W; i++) o[HALF_W-1-i] = h[HALF_W - P_TABLE[i]];
        return o;
    endfunction

    // parity bits dropped here
    function automatic des_cd_t des_pc1(input des_key_t k);
        des_cd_t o;
        for (int i = 0; i < 2*CD_W; i++) o[2*CD_W-1-i] = k[KEY_W - PC1_TABLE[i]];
        return o;
    endfunction

    function automatic des_subkey_t des_pc2(input des_cd_t cd);
        des_subkey_t o;
        for (int i = 0; i < SUBKEY_W; i++) o[SUBKEY_W-1-i] = cd[2*CD_W - PC2_TABLE[i]];
        return o;
    endfunction

endpackage

// ==== logic/des_round_f.sv ====
`timescale 1ns/1ps

module des_round_f (
    input  des_pkg::des_half_t   r_half,
    input  des_pkg::des_subkey_t subkey,
    output des_pkg::des_half_t   f_out
);

    des_pkg::des_subkey_t mixed;
    des_pkg::des_half_t   sbox_out;

    assign mixed = des_pkg::des_expand(r_half) ^ subkey;

    always_comb begin
        logic [5:0] group;
        logic [1:0] row;
        logic [3:0] col;
        sbox_out = '0;
        // group 0 sits at the msb end and feeds S1
        for (int g = 0; g < 8; g++) begin
            group = mixed[des_pkg::SUBKEY_W-1-6*g -: 6];
            row   = {group[5], group[0]};
            col   = group[4:1];
            sbox_out[des_pkg::HALF_W-1-4*g -: 4] = des_pkg::SBOX_TABLE[g][{row, col}];
        end
    end

    assign f_out = des_pkg::des_perm_p(sbox_out);

endmodule

// ==== verif/des_tb.sv ====
`timescale 1ns/1ps

module des_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int NUM_REQUESTS = 47;
    localparam int WATCHDOG_CYC = NUM_REQUESTS * 20 + 100;

    localparam des_pkg::des_key_t   KAT_KEY    = 64'h133457799BBCDFF1;
    localparam des_pkg::des_block_t KAT_PLAIN  = 64'h0123456789ABCDEF;
    localparam des_pkg::des_block_t KAT_CIPHER = 64'h85E813540F0AB405;

    logic                clk;
    logic                rst_n;
    logic                start;
    des_pkg::des_req_t   req;
    logic                busy;
    logic                done;
    des_pkg::des_block_t dout;

    des_core u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .dout  (dout)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("timeout: the run did not finish in %0d cycles", WATCHDOG_CYC);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                            input string msg);
        if (actual !== expected) begin
            $display("** Error at %0t: %s: got %h, expected %h", $time, msg, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // one request from idle, result sampled in the done cycle
    task automatic run_block(input logic dec, input des_pkg::des_key_t key,
                             input des_pkg::des_block_t blk,
                             output des_pkg::des_block_t result);
        int cycles;
        @(posedge clk);
        #1;
        check_eq(busy, 1'b0, "busy before request");
        start       = 1'b1;
        req.decrypt = dec;
        req.key     = key;
        req.block   = blk;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_eq(busy, 1'b1, "busy after accept");
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!done);
        check_eq(cycles, 16, "accept to done latency");
        check_eq(busy, 1'b0, "busy in done cycle");
        result = dout;
        @(posedge clk);
        #1;
        check_eq(done, 1'b0, "done lasts one cycle");
    endtask

    task automatic reset_values();
        check_eq(busy, 1'b0, "busy after reset");
        check_eq(done, 1'b0, "done after reset");
        check_eq(dout, 64'h0, "dout after reset");
    endtask

    task automatic known_answer();
        des_pkg::des_block_t res;
        run_block(1'b0, KAT_KEY, KAT_PLAIN, res);
        check_eq(res, KAT_CIPHER, "known answer encrypt");
        run_block(1'b1, KAT_KEY, KAT_CIPHER, res);
        check_eq(res, KAT_PLAIN, "known answer decrypt");
    endtask

    task automatic round_trip();
        des_pkg::des_key_t   key;
        des_pkg::des_block_t blk;
        des_pkg::des_block_t enc;
        des_pkg::des_block_t dec;
        for (int i = 0; i < 20; i++) begin
            key = rand64();
            blk = rand64();
            run_block(1'b0, key, blk, enc);
            run_block(1'b1, key, enc, dec);
            check_eq(dec, blk, $sformatf("round trip %0d", i));
        end
    endtask

    task automatic complement_property();
        des_pkg::des_key_t   key;
        des_pkg::des_block_t blk;
        des_pkg::des_block_t c0;
        des_pkg::des_block_t c1;
        key = rand64();
        blk = rand64();
        run_block(1'b0, key, blk, c0);
        run_block(1'b0, ~key, ~blk, c1);
        check_eq(c1, ~c0, "complement property");
    endtask

    task automatic weak_key_involution();
        des_pkg::des_block_t blk;
        des_pkg::des_block_t c0;
        des_pkg::des_block_t c1;
        blk = rand64();
        run_block(1'b0, 64'h0101010101010101, blk, c0);
        run_block(1'b0, 64'h0101010101010101, c0, c1);
        check_eq(c1, blk, "weak key double encrypt");
    endtask

    task automatic start_while_busy();
        int cycles;
        @(posedge clk);
        #1;
        start       = 1'b1;
        req.decrypt = 1'b0;
        req.key     = KAT_KEY;
        req.block   = KAT_PLAIN;
        @(posedge clk);
        #1;
        start  = 1'b0;
        cycles = 0;
        repeat (4) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        // second request mid run, must be dropped
        start       = 1'b1;
        req.decrypt = 1'b1;
        req.key     = rand64();
        req.block   = rand64();
        do begin
            @(posedge clk);
            #1;
            cycles++;
            start = 1'b0;
        end while (!done);
        check_eq(cycles, 16, "latency with start while busy");
        check_eq(dout, KAT_CIPHER, "result with start while busy");
        repeat (5) begin
            @(posedge clk);
            #1;
            check_eq(done, 1'b0, "no done after ignored start");
            check_eq(busy, 1'b0, "idle after ignored start");
            check_eq(dout, KAT_CIPHER, "dout held");
        end
    endtask

    initial begin
        void'($urandom(32'h76cf26a1));
        rst_n = 1'b0;
        start = 1'b0;
        req   = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_values();
        known_answer();
        round_trip();
        complement_property();
        weak_key_involution();
        start_while_busy();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
